//--- sources.f
rtl/seg_mem_pkg.sv
rtl/seg_mem_req_decode.sv
rtl/seg_mem_bank_array.sv
rtl/seg_mem_read_hold.sv
rtl/seg_mem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_seg_mem.sv

//--- Bender.yml
package:
  name: seg_mem

sources:
  # design, in compile order
  - rtl/seg_mem_pkg.sv
  - rtl/seg_mem_req_decode.sv
  - rtl/seg_mem_bank_array.sv
  - rtl/seg_mem_read_hold.sv
  - rtl/seg_mem_top.sv

  # testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_seg_mem.sv

//--- testbench/tb_seg_mem.sv
`timescale 1ns/1ps

module tb_seg_mem;

  import seg_mem_pkg::*;

  localparam int RST_CYC = 16;
  localparam int MIX_CYC = 300;
  // idle + full rw + masked + seg subset + partial reads + mix + drain
  localparam int RUN_CYC = 2 + 2*ELS + 3*ELS + 2*ELS + 3*ELS + MIX_CYC + 3;
  localparam int MAX_CYC = RST_CYC + RUN_CYC + 50;  // small margin

  logic        clk;
  logic        rst_i;
  mem_req_t    req;
  seg_word_u   data_o;
  int          cyc_cnt = 0;
  logic [31:0] lcg_state = 32'd91;  // seed

  // reference state
  seg_word_u shadow [ELS];
  seg_word_u held;  // last value read, per segment

  tb_clock_gen #(.period_p(8.0)) u_clock_gen (.clk_o(clk));

  seg_mem_top #(
    .latch_last_read_p (1'b1)
  ) UUT (
    .clk    (clk),
    .rst_i  (rst_i),
    .req_i  (req),
    .data_o (data_o)
  );

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic seg_word_u rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    seg_word_u   w;
    hi = lcg_next();
    lo = lcg_next();
    w  = {hi, lo};
    return w;
  endfunction

  // read segments show the addressed word and the rest keep the held copy
  function automatic seg_word_u expect_out(input seg_word_u          rd_word,
                                           input logic [NUM_SEG-1:0] rd_seg,
                                           input seg_word_u          last);
    seg_word_u res;
    for (int s = 0; s < NUM_SEG; s++) begin
      res.segs[s] = rd_seg[s] ? rd_word.segs[s] : last.segs[s];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input seg_word_u got, input seg_word_u exp);
    logic bad;
    bad = 1'b0;
    for (int s = 0; s < NUM_SEG; s++) begin
      if (got.segs[s] !== exp.segs[s]) begin
        $display("error: data_o.segs[%0d] got %h exp %h", s, got.segs[s], exp.segs[s]);
        bad = 1'b1;
      end
    end
    if (bad) begin
      fail_run($sformatf("error: data_o got %h exp %h", got, exp));
    end
  endtask

  task automatic check_idle(input seg_rd_t rd, input seg_word_u out);
    if (rd.rd_valid !== '0) begin
      fail_run($sformatf("error: rd_valid got %h exp %h", rd.rd_valid, {NUM_SEG{1'b0}}));
    end
    if (rd.data !== '0) begin
      fail_run($sformatf("error: rd_data got %h exp %h", rd.data, {DATA_W{1'b0}}));
    end
    if (out !== '0) begin
      fail_run($sformatf("error: data_o got %h exp %h", out, {DATA_W{1'b0}}));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic drive_write(input logic [ADDR_W-1:0]    addr,
                             input logic [NUM_SEG-1:0]   seg_v,
                             input logic [NUM_BYTES-1:0] mask,
                             input seg_word_u            data);
    @(negedge clk);
    req.seg_v     = seg_v;
    req.we        = 1'b1;
    req.addr      = addr;
    req.data      = data;
    req.byte_mask = mask;
  endtask

  task automatic drive_read(input logic [ADDR_W-1:0] addr, input logic [NUM_SEG-1:0] seg_v);
    @(negedge clk);
    req.seg_v     = seg_v;
    req.we        = 1'b0;
    req.addr      = addr;
    req.data      = '0;
    req.byte_mask = '0;
  endtask

  task automatic drive_idle();
    @(negedge clk);
    req = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // checker and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : compare_proc
    mem_req_t           s_req;
    logic               s_rst;
    seg_word_u          rd_word;
    logic [NUM_SEG-1:0] rd_seg;
    seg_word_u          exp;
    s_req   = req;  // stable since the falling edge
    s_rst   = rst_i;
    rd_word = '0;
    rd_seg  = '0;
    if (s_rst) begin
      held = '0;
    end else begin
      if (s_req.we) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (s_req.seg_v[b / SEG_BYTES] && s_req.byte_mask[b]) begin
            shadow[s_req.addr].bytes[b] = s_req.data.bytes[b];
          end
        end
      end else begin
        rd_seg  = s_req.seg_v;
        rd_word = shadow[s_req.addr];
      end
      exp  = expect_out(rd_word, rd_seg, held);
      held = exp;
      #2;  // let the edge settle
      check_word(data_o, exp);
    end
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > MAX_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    rst_i     = 1'b1;
    req       = '0;
    req.seg_v = '1;  // read request held across reset
    repeat (RST_CYC) @(negedge clk);
    rst_i = 1'b0;
    req   = '0;
    check_idle(UUT.bank_rd, data_o);  // reset values, nothing read yet

    drive_idle();
    drive_idle();

    // full writes then full reads
    for (int i = 0; i < ELS; i++) drive_write(i[ADDR_W-1:0], '1, '1, rand_word());
    for (int i = 0; i < ELS; i++) drive_read(i[ADDR_W-1:0], '1);

    // random byte masks
    for (int i = 0; i < 2*ELS; i++) begin
      r = lcg_next();
      drive_write(r[27:24], '1, r[23:16], rand_word());
    end
    for (int i = 0; i < ELS; i++) drive_read(i[ADDR_W-1:0], '1);

    // segment subsets on write
    for (int i = 0; i < ELS; i++) begin
      r = lcg_next();
      drive_write(i[ADDR_W-1:0], r[27:24], '1, rand_word());
    end
    for (int i = 0; i < ELS; i++) drive_read(i[ADDR_W-1:0], '1);

    // partial reads where unread segments hold
    for (int i = 0; i < ELS; i++) drive_write(i[ADDR_W-1:0], '1, '1, rand_word());
    for (int i = 0; i < 2*ELS; i++) begin
      r = lcg_next();
      drive_read(r[27:24], r[23:20]);
    end

    // random mix
    for (int i = 0; i < MIX_CYC; i++) begin
      r = lcg_next();
      if (r[31]) begin
        drive_write(r[27:24], r[23:20], r[19:12], rand_word());
      end else begin
        drive_read(r[27:24], r[23:20]);
      end
    end

    repeat (3) drive_idle();  // drain last compare
    $display("Regression passed");
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime period_p = 8.0  // ns
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_p / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- rtl/seg_mem_top.sv
`timescale 1ns/1ps

module seg_mem_top #(
  parameter bit latch_last_read_p = 1'b0  // keep last read per segment
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  seg_mem_pkg::mem_req_t  req_i,
  output seg_mem_pkg::seg_word_u data_o
);

  import seg_mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // stage links
  ////////////////////////////////////////////////////////////

  bank_cmd_t bank_cmd;  // decode -> array, same cycle
  seg_rd_t   bank_rd;   // array -> hold, one cycle later

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  seg_mem_req_decode u_req_decode (
    .req_i (req_i),
    .cmd_o (bank_cmd)
  );

  ////////////////////////////////////////////////////////////
  // storage and read register
  ////////////////////////////////////////////////////////////

  seg_mem_bank_array u_bank_array (
    .clk   (clk),
    .rst_i (rst_i),
    .cmd_i (bank_cmd),
    .rd_o  (bank_rd)
  );

  ////////////////////////////////////////////////////////////
  // read hold
  ////////////////////////////////////////////////////////////

  seg_mem_read_hold #(
    .latch_last_read_p (latch_last_read_p)
  ) u_read_hold (
    .clk    (clk),
    .rst_i  (rst_i),
    .rd_i   (bank_rd),
    .data_o (data_o)
  );

endmodule

//--- rtl/seg_mem_read_hold.sv
`timescale 1ns/1ps

module seg_mem_read_hold #(
  parameter bit latch_last_read_p = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  seg_mem_pkg::seg_rd_t  rd_i,
  output seg_mem_pkg::seg_word_u data_o
);

  import seg_mem_pkg::*;

  if (latch_last_read_p) begin : g_hold

    ////////////////////////////////////////////////////////////
    // per segment holding registers
    ////////////////////////////////////////////////////////////

    logic [NUM_SEG-1:0][SEG_W-1:0] hold_q;

    // capture each segment on the cycle its fresh data shows up
    always_ff @(posedge clk) begin
      if (rst_i) begin
        hold_q <= '0;
      end else begin
        for (int s = 0; s < NUM_SEG; s++) begin
          if (rd_i.rd_valid[s]) begin
            hold_q[s] <= rd_i.data.segs[s];
          end
        end
      end
    end

    // fresh data when just read, else the last value read
    always_comb begin
      for (int s = 0; s < NUM_SEG; s++) begin
        data_o.segs[s] = rd_i.rd_valid[s] ? rd_i.data.segs[s] : hold_q[s];
      end
    end

  end else begin : g_pass

    // follows the read register directly
    // unread segments show whatever the shared read loaded
    assign data_o = rd_i.data;

  end

endmodule

//--- rtl/seg_mem_bank_array.sv
`timescale 1ns/1ps

module seg_mem_bank_array (
  input  logic                   clk,
  input  logic                   rst_i,
  input  seg_mem_pkg::bank_cmd_t cmd_i,
  output seg_mem_pkg::seg_rd_t   rd_o
);

  import seg_mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  // ELS words, each kept as NUM_BYTES separate bytes
  logic [NUM_BYTES-1:0][7:0] mem_q [ELS];

  logic any_rd;

  // segment valids are ORed, the whole word is read together
  assign any_rd = |cmd_i.rd_en;

  // byte writes, contents never cleared
  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (cmd_i.byte_we[b]) begin
        mem_q[cmd_i.addr][b] <= cmd_i.data.bytes[b];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read register
  ////////////////////////////////////////////////////////////

  seg_word_u          rd_data_q;
  logic [NUM_SEG-1:0] rd_valid_q;

  // loaded on any read, a write leaves it alone
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_data_q <= '0;
    end else if (any_rd) begin
      rd_data_q <= mem_q[cmd_i.addr];
    end
  end

  // which segments were asked for last cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rd_valid_q <= '0;
    end else begin
      rd_valid_q <= cmd_i.rd_en;  // zero on writes and idle cycles
    end
  end

  ////////////////////////////////////////////////////////////
  // output
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_o.rd_valid = rd_valid_q;
    rd_o.data     = rd_data_q;
  end

endmodule

//--- rtl/seg_mem_req_decode.sv
`timescale 1ns/1ps

module seg_mem_req_decode (
  input  seg_mem_pkg::mem_req_t  req_i,
  output seg_mem_pkg::bank_cmd_t cmd_o
);

  import seg_mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // write enables
  ////////////////////////////////////////////////////////////

  logic [NUM_BYTES-1:0] byte_we;

  // a byte is written when its segment is valid and its mask bit is set
  always_comb begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      byte_we[b] = req_i.we
                 & req_i.seg_v[b / SEG_BYTES]  // owning segment
                 & req_i.byte_mask[b];
    end
  end

  ////////////////////////////////////////////////////////////
  // read enables
  ////////////////////////////////////////////////////////////

  logic [NUM_SEG-1:0] rd_en;

  always_comb begin
    for (int s = 0; s < NUM_SEG; s++) begin
      rd_en[s] = ~req_i.we & req_i.seg_v[s];  // read only on we low
    end
  end

  ////////////////////////////////////////////////////////////
  // command out
  ////////////////////////////////////////////////////////////

  // addr and data pass through unchanged
  always_comb begin
    cmd_o.rd_en   = rd_en;
    cmd_o.byte_we = byte_we;
    cmd_o.addr    = req_i.addr;
    cmd_o.data    = req_i.data;
  end

endmodule

//--- rtl/seg_mem_pkg.sv
package seg_mem_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int DATA_W    = 64;  // full memory word
  localparam int NUM_SEG   = 4;
  localparam int SEG_W     = 16;  // bits per segment
  localparam int SEG_BYTES = 2;   // bytes per segment
  localparam int NUM_BYTES = 8;   // bytes per word
  localparam int ELS       = 16;  // entries
  localparam int ADDR_W    = 4;

  ////////////////////////////////////////////////////////////
  // data word
  ////////////////////////////////////////////////////////////

  // one 64 bit word, seen as segments by the valids and the read
  // path, and as bytes by the write mask
  typedef union packed {
    logic [NUM_SEG-1:0][SEG_W-1:0] segs;
    logic [NUM_BYTES-1:0][7:0]     bytes;
  } seg_word_u;

  ////////////////////////////////////////////////////////////
  // request and bank command
  ////////////////////////////////////////////////////////////

  // request as it arrives from outside
  typedef struct packed {
    logic [NUM_SEG-1:0]   seg_v;      // segment valids
    logic                 we;         // 1 = write, 0 = read
    logic [ADDR_W-1:0]    addr;
    seg_word_u            data;
    logic [NUM_BYTES-1:0] byte_mask;  // bytes to write
  } mem_req_t;

  // decoded command into the storage array
  typedef struct packed {
    logic [NUM_SEG-1:0]   rd_en;
    logic [NUM_BYTES-1:0] byte_we;
    logic [ADDR_W-1:0]    addr;
    seg_word_u            data;
  } bank_cmd_t;

  // registered read result
  typedef struct packed {
    logic [NUM_SEG-1:0] rd_valid;  // segments read last cycle
    seg_word_u          data;
  } seg_rd_t;

endpackage
